// File: Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module rvfi_trace_top
	verilator --lint-only --timing -f filelist.f --top-module tb_rvfi_trace

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_rvfi_trace -Mdir obj_dir
	./obj_dir/Vtb_rvfi_trace | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_rvfi_trace.sv
`include "rvfi_trace_macros.svh"

module tb_rvfi_trace;

  timeunit 1ns;
  timeprecision 1ps;

  import rvfi_trace_pkg::*;

  // Rough length of all stimulus, in clock cycles
  localparam int STIM_CYCLES = 700;
  localparam int WATCHDOG_CYCLES = STIM_CYCLES * 4 + 1000;
  localparam int unsigned DELTA_MAX = (1 << `RVFI_TRACE_DELTA_W) - 1;

  logic        clk;
  logic        rst_n;
  logic        trace_enable;
  logic        trace_rd;
  logic        rvfi_valid;
  logic [31:0] rvfi_pc_rdata;
  logic [4:0]  rvfi_rd_addr;
  logic [31:0] rvfi_rd_wdata;
  logic [31:0] rvfi_mem_addr;
  logic [3:0]  rvfi_mem_rmask;
  logic [3:0]  rvfi_mem_wmask;
  logic [31:0] trace_data;
  logic        trace_empty;
  logic        trace_overflow;

  // Strobe is part of the reference model when set
  logic        track;
  logic        flood_on;
  logic [31:0] seed;
  int unsigned edge_no;
  int unsigned last_acc;
  logic [31:0] exp_q[$];
  logic [31:0] exp_head;
  logic        exp_avail;
  int          errors;
  int          checked;
  string       test_name;

  rvfi_trace_top i_rvfi_trace_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .trace_enable   (trace_enable),
    .trace_rd       (trace_rd),
    .rvfi_valid     (rvfi_valid),
    .rvfi_pc_rdata  (rvfi_pc_rdata),
    .rvfi_rd_addr   (rvfi_rd_addr),
    .rvfi_rd_wdata  (rvfi_rd_wdata),
    .rvfi_mem_addr  (rvfi_mem_addr),
    .rvfi_mem_rmask (rvfi_mem_rmask),
    .rvfi_mem_wmask (rvfi_mem_wmask),
    .trace_data     (trace_data),
    .trace_empty    (trace_empty),
    .trace_overflow (trace_overflow)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Runs on the values the DUT samples at this edge
  always @(posedge clk) begin : model
    trace_word_u hdr_w;
    int unsigned gap;
    if (!rst_n) begin
      edge_no  = 0;
      last_acc = 0;
      exp_q.delete();
    end else begin
      edge_no++;
      if (trace_rd && !trace_empty && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        checked++;
      end
      if (rvfi_valid && trace_enable && track) begin
        // Edges since the previous accept, held at all ones
        gap = edge_no - last_acc;
        if (gap > DELTA_MAX) begin
          gap = DELTA_MAX;
        end
        hdr_w               = '0;
        hdr_w.hdr.kind      = KIND_HDR;
        hdr_w.hdr.has_rd    = (rvfi_rd_addr != 5'd0);
        hdr_w.hdr.has_mem   = (rvfi_mem_rmask != 4'd0) || (rvfi_mem_wmask != 4'd0);
        hdr_w.hdr.mem_write = (rvfi_mem_wmask != 4'd0);
        hdr_w.hdr.rd_addr   = rvfi_rd_addr;
        hdr_w.hdr.delta     = `RVFI_TRACE_DELTA_W'(gap);
        exp_q.push_back(hdr_w.raw);
        exp_q.push_back(rvfi_pc_rdata);
        if (rvfi_rd_addr != 5'd0) begin
          exp_q.push_back(rvfi_rd_wdata);
        end
        if (hdr_w.hdr.has_mem) begin
          exp_q.push_back(rvfi_mem_addr);
        end
        last_acc = edge_no;
      end
    end
    exp_avail = (exp_q.size() != 0);
    exp_head  = exp_avail ? exp_q[0] : 32'h0;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Every popped word against the head of the model
  word_check: assert property (@(posedge clk) disable iff (!rst_n)
      (trace_rd && !trace_empty && exp_avail) |-> (trace_data == exp_head))
    else begin
      errors++;
      $display("[FAIL] %s: expected %08h, actual %08h", test_name,
               $sampled(exp_head), $sampled(trace_data));
    end

  extra_check: assert property (@(posedge clk) disable iff (!rst_n)
      (trace_rd && !trace_empty) |-> exp_avail)
    else begin
      errors++;
      $display("%s: trace word %08h popped with nothing expected", test_name,
               $sampled(trace_data));
    end

  // Flags held while reset is low
  reset_check: assert property (@(posedge clk) !rst_n |-> (trace_empty && !trace_overflow))
    else begin
      errors++;
      $display("%s: buffer not empty or overflow set during reset", test_name);
    end

  no_drop_check: assert property (@(posedge clk) disable iff (!rst_n)
      !flood_on |-> !trace_overflow)
    else begin
      errors++;
      $display("%s: overflow set while reads kept up", test_name);
    end

  sticky_check: assert property (@(posedge clk) disable iff (!rst_n)
      $past(trace_overflow) |-> trace_overflow)
    else begin
      errors++;
      $display("%s: overflow cleared without reset", test_name);
    end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic send_retire(input logic [31:0] pc, input logic [4:0] rd,
                             input logic [31:0] wdata, input logic [31:0] addr,
                             input logic [3:0] rmask, input logic [3:0] wmask,
                             input logic trk);
    @(posedge clk);
    rvfi_valid     <= 1'b1;
    rvfi_pc_rdata  <= pc;
    rvfi_rd_addr   <= rd;
    rvfi_rd_wdata  <= wdata;
    rvfi_mem_addr  <= addr;
    rvfi_mem_rmask <= rmask;
    rvfi_mem_wmask <= wmask;
    track          <= trk;
  endtask

  // Random fields, rd x0 about a quarter of the time
  task automatic send_random(input logic trk);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [4:0]  rd;
    r1    = next_rand();
    r2    = next_rand();
    rmask = 4'd0;
    wmask = 4'd0;
    rd    = (r2[7:6] == 2'b00) ? 5'd0 : r2[4:0];
    case (r2[9:8])
      2'd1:    rmask = 4'b0001 << r2[11:10];
      2'd2:    wmask = 4'b1111;
      default: rmask = 4'd0;
    endcase
    send_retire({r1[31:2], 2'b00}, rd, next_rand(), r1 ^ r2, rmask, wmask, trk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      rvfi_valid <= 1'b0;
      track      <= 1'b0;
    end
  endtask

  // Single pop pulses, one word at a time
  task automatic drain_words(input int n);
    repeat (n) begin
      do @(posedge clk); while (trace_empty);
      trace_rd <= 1'b1;
      @(posedge clk);
      trace_rd <= 1'b0;
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    assert (trace_empty) else begin
      errors++;
      $display("[FAIL] %s: expected trace_empty 1, actual %0b", test_name, trace_empty);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (trace_empty && !trace_overflow) else begin
      errors++;
      $display("%s: wrong flags right after reset release", test_name);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run stopped by the watchdog after %0d cycles in test %s", WATCHDOG_CYCLES,
             test_name);
    $display("errors=%0d words_checked=%0d", errors, checked);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    logic b2b_prev;
    clk            = 1'b0;
    rst_n          = 1'b0;
    trace_enable   = 1'b1;
    trace_rd       = 1'b0;
    rvfi_valid     = 1'b0;
    rvfi_pc_rdata  = 32'h0;
    rvfi_rd_addr   = 5'd0;
    rvfi_rd_wdata  = 32'h0;
    rvfi_mem_addr  = 32'h0;
    rvfi_mem_rmask = 4'd0;
    rvfi_mem_wmask = 4'd0;
    track          = 1'b0;
    flood_on       = 1'b0;
    seed           = 32'hdce534fb;
    errors         = 0;
    checked        = 0;
    test_name      = "reset";
    b2b_prev       = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (trace_empty && !trace_overflow) else begin
      errors++;
      $display("reset: wrong flags right after reset release");
    end

    // First record delta counts from reset release
    test_name = "record_format";
    trace_rd <= 1'b1;
    repeat (50) begin
      send_random(1'b1);
      // Occasional back-to-back pair, never a longer run
      if (seed[12:10] != 3'd0 || b2b_prev) begin
        idle_cycles(2 + int'(next_rand() % 7));
        b2b_prev = 1'b0;
      end else begin
        b2b_prev = 1'b1;
      end
    end
    idle_cycles(1);
    wait_drained();

    test_name = "optional_words";
    send_retire(32'h0000_1000, 5'd0, 32'hdead_0001, 32'h0, 4'd0, 4'd0, 1'b1);
    idle_cycles(5);
    send_retire(32'h0000_1004, 5'd5, 32'h1234_5678, 32'h8000_0010, 4'b0011, 4'd0, 1'b1);
    idle_cycles(5);
    send_retire(32'h0000_1008, 5'd0, 32'hdead_0002, 32'h8000_0020, 4'd0, 4'b1111, 1'b1);
    idle_cycles(5);
    send_retire(32'h0000_100c, 5'd31, 32'hcafe_f00d, 32'h8000_0030, 4'd0, 4'b0100, 1'b1);
    idle_cycles(5);
    wait_drained();

    // Three strobes on consecutive edges, delta 1 twice
    test_name = "delta_b2b";
    send_retire(32'h0000_2000, 5'd1, 32'h1, 32'h0, 4'd0, 4'd0, 1'b1);
    send_retire(32'h0000_2004, 5'd2, 32'h2, 32'h0, 4'd0, 4'd0, 1'b1);
    send_retire(32'h0000_2008, 5'd0, 32'h3, 32'h9000_0000, 4'b1000, 4'd0, 1'b1);
    idle_cycles(3);
    wait_drained();

    test_name = "enable_low";
    trace_enable <= 1'b0;
    repeat (8) begin
      send_random(1'b1);
      idle_cycles(1);
    end
    repeat (20) begin
      @(posedge clk);
      assert (trace_empty) else begin
        errors++;
        $display("[FAIL] %s: expected trace_empty 1, actual 0", test_name);
      end
    end
    trace_enable <= 1'b1;

    // Only the first four strobes of the flood are modeled
    test_name = "overflow";
    flood_on  = 1'b1;
    trace_rd <= 1'b0;
    for (int i = 0; i < 40; i++) begin
      send_random(i < 4);
    end
    idle_cycles(2);
    assert (trace_overflow) else begin
      errors++;
      $display("[FAIL] %s: expected trace_overflow 1, actual 0", test_name);
    end
    drain_words(exp_q.size());
    repeat (10) @(posedge clk);
    assert (trace_overflow && exp_q.size() == 0) else begin
      errors++;
      $display("%s: overflow dropped or records left after drain", test_name);
    end

    test_name = "reset_state";
    apply_reset();
    flood_on = 1'b0;
    repeat (5) @(posedge clk);

    $display("errors=%0d words_checked=%0d", errors, checked);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
hdl/rvfi_trace_pkg.sv
hdl/retire_queue.sv
hdl/retire_delta_timer.sv
hdl/trace_record_fsm.sv
hdl/trace_word_fifo.sv
hdl/rvfi_trace_top.sv
dv/tb_rvfi_trace.sv

// File: hdl/retire_delta_timer.sv
`include "rvfi_trace_macros.svh"

module retire_delta_timer (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           accept,
  output logic [`RVFI_TRACE_DELTA_W-1:0] delta
);

  logic [`RVFI_TRACE_DELTA_W-1:0] cnt_q;

  // Edges since the previous accept, counting the coming edge
  // First edge after reset release counts as one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= `RVFI_TRACE_DELTA_W'(1);
    end else if (accept) begin
      // Restart so that back-to-back strobes give one
      cnt_q <= `RVFI_TRACE_DELTA_W'(1);
    end else if (cnt_q != '1) begin
      // Hold at all ones on long gaps
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Sampled by the queue at the accepting edge
  assign delta = cnt_q;

endmodule

// File: hdl/retire_queue.sv
`include "rvfi_trace_macros.svh"

module retire_queue (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           trace_enable,
  input  logic                           rvfi_valid,
  input  logic [31:0]                    rvfi_pc_rdata,
  input  logic [4:0]                     rvfi_rd_addr,
  input  logic [31:0]                    rvfi_rd_wdata,
  input  logic [31:0]                    rvfi_mem_addr,
  input  logic [3:0]                     rvfi_mem_rmask,
  input  logic [3:0]                     rvfi_mem_wmask,
  input  logic [`RVFI_TRACE_DELTA_W-1:0] delta,
  input  logic                           ret_pop,
  output logic                           ret_valid,
  output rvfi_trace_pkg::retire_t        ret_entry,
  output logic                           accept,
  output logic                           overflow
);

  import rvfi_trace_pkg::*;

  localparam int DEPTH = `RVFI_TRACE_RETQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  retire_t            mem_q [DEPTH];
  retire_t            wr_entry;
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               full;
  logic               pop;

  //////////////////////////////
  // Capture side
  //////////////////////////////

  assign full = (count_q == CNT_W'(DEPTH));

  // Strobe is taken only while tracing and with room left
  assign accept = rvfi_valid & trace_enable & ~full;

  // Pop of an empty queue is ignored
  assign pop = ret_pop & ret_valid;

  // Reduce byte masks to direction flags on the way in
  always_comb begin
    wr_entry.pc        = rvfi_pc_rdata;
    wr_entry.rd_addr   = rvfi_rd_addr;
    wr_entry.rd_wdata  = rvfi_rd_wdata;
    wr_entry.mem_addr  = rvfi_mem_addr;
    wr_entry.mem_read  = |rvfi_mem_rmask;
    wr_entry.mem_write = |rvfi_mem_wmask;
    wr_entry.delta     = delta;
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (accept) begin
      mem_q[wr_ptr_q] <= wr_entry;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (accept) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous accept and pop leave the count as is
      if (accept && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !accept) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Sticky drop flag held until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (rvfi_valid && trace_enable && full) begin
      overflow <= 1'b1;
    end
  end

  // Head of queue
  assign ret_valid = (count_q != '0);
  assign ret_entry = mem_q[rd_ptr_q];

endmodule

// File: hdl/rvfi_trace_pkg.sv
`include "rvfi_trace_macros.svh"

package rvfi_trace_pkg;

  //////////////////////////////
  // Trace word encoding
  //////////////////////////////

  // Kind code in the top bits of a header
  typedef enum logic [1:0] {
    KIND_HDR = 2'd0,
    KIND_PC  = 2'd1,
    KIND_RD  = 2'd2,
    KIND_MEM = 2'd3
  } trace_kind_e;

  // First word of every record
  typedef struct packed {
    trace_kind_e                   kind;
    logic                          has_rd;
    logic                          has_mem;
    logic                          mem_write;
    logic [4:0]                    rd_addr;
    logic [`RVFI_TRACE_DELTA_W-1:0] delta;
  } trace_hdr_t;

  // Header view or raw payload view of the same word
  typedef union packed {
    trace_hdr_t  hdr;
    logic [31:0] raw;
  } trace_word_u;

  // One retirement as kept in the queue
  // Masks are already reduced to flags
  typedef struct packed {
    logic [31:0]                    pc;
    logic [4:0]                     rd_addr;
    logic [31:0]                    rd_wdata;
    logic [31:0]                    mem_addr;
    logic                           mem_read;
    logic                           mem_write;
    logic [`RVFI_TRACE_DELTA_W-1:0] delta;
  } retire_t;

endpackage

// File: hdl/rvfi_trace_top.sv
`include "rvfi_trace_macros.svh"

module rvfi_trace_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        trace_enable,
  input  logic                        trace_rd,
  input  logic                        rvfi_valid,
  input  logic [31:0]                 rvfi_pc_rdata,
  input  logic [4:0]                  rvfi_rd_addr,
  input  logic [31:0]                 rvfi_rd_wdata,
  input  logic [31:0]                 rvfi_mem_addr,
  input  logic [3:0]                  rvfi_mem_rmask,
  input  logic [3:0]                  rvfi_mem_wmask,
  output rvfi_trace_pkg::trace_word_u trace_data,
  output logic                        trace_empty,
  output logic                        trace_overflow
);

  import rvfi_trace_pkg::*;

  // Queue to emitter
  logic                           ret_valid;
  retire_t                        ret_entry;
  logic                           ret_pop;
  // Queue and timer
  logic                           accept;
  logic [`RVFI_TRACE_DELTA_W-1:0] delta;
  // Emitter to buffer
  logic                           fifo_push;
  trace_word_u                    fifo_word;
  logic                           fifo_full;

  //////////////////////////////
  // Capture
  //////////////////////////////

  retire_queue i_retire_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .trace_enable   (trace_enable),
    .rvfi_valid     (rvfi_valid),
    .rvfi_pc_rdata  (rvfi_pc_rdata),
    .rvfi_rd_addr   (rvfi_rd_addr),
    .rvfi_rd_wdata  (rvfi_rd_wdata),
    .rvfi_mem_addr  (rvfi_mem_addr),
    .rvfi_mem_rmask (rvfi_mem_rmask),
    .rvfi_mem_wmask (rvfi_mem_wmask),
    .delta          (delta),
    .ret_pop        (ret_pop),
    .ret_valid      (ret_valid),
    .ret_entry      (ret_entry),
    .accept         (accept),
    .overflow       (trace_overflow)
  );

  retire_delta_timer i_retire_delta_timer (
    .clk    (clk),
    .rst_n  (rst_n),
    .accept (accept),
    .delta  (delta)
  );

  //////////////////////////////
  // Emit and buffer
  //////////////////////////////

  trace_record_fsm i_trace_record_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .ret_valid (ret_valid),
    .ret_entry (ret_entry),
    .fifo_full (fifo_full),
    .ret_pop   (ret_pop),
    .fifo_push (fifo_push),
    .fifo_word (fifo_word)
  );

  trace_word_fifo i_trace_word_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .fifo_push   (fifo_push),
    .fifo_word   (fifo_word),
    .trace_rd    (trace_rd),
    .trace_data  (trace_data),
    .trace_empty (trace_empty),
    .fifo_full   (fifo_full)
  );

endmodule

// File: hdl/trace_record_fsm.sv
module trace_record_fsm (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ret_valid,
  input  rvfi_trace_pkg::retire_t     ret_entry,
  input  logic                        fifo_full,
  output logic                        ret_pop,
  output logic                        fifo_push,
  output rvfi_trace_pkg::trace_word_u fifo_word
);

  import rvfi_trace_pkg::*;

  // State is a busy flag plus the kind of word due next
  // Idle when busy is low
  logic        busy_q;
  logic        busy_d;
  trace_kind_e kind_q;
  trace_kind_e kind_d;
  logic        has_rd;
  logic        has_mem;
  logic        last_word;

  //////////////////////////////
  // Record shape
  //////////////////////////////

  // x0 writes carry no data word
  assign has_rd  = (ret_entry.rd_addr != 5'd0);
  assign has_mem = ret_entry.mem_read | ret_entry.mem_write;

  // Word due now closes the record
  always_comb begin
    case (kind_q)
      KIND_PC:  last_word = ~has_rd & ~has_mem;
      KIND_RD:  last_word = ~has_mem;
      KIND_MEM: last_word = 1'b1;
      default:  last_word = 1'b0;
    endcase
  end

  // One word per cycle unless the buffer is full
  assign fifo_push = busy_q & ret_valid & ~fifo_full;

  // Entry leaves with its final word
  // Next head is seen a cycle later
  assign ret_pop = fifo_push & last_word;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    busy_d = busy_q;
    kind_d = kind_q;
    if (!busy_q) begin
      if (ret_valid) begin
        busy_d = 1'b1;
        kind_d = KIND_HDR;
      end
    end else if (!ret_valid) begin
      // Header due but queue ran dry after the last pop
      busy_d = 1'b0;
      kind_d = KIND_HDR;
    end else if (fifo_push) begin
      if (last_word) begin
        // Straight into the next header
        kind_d = KIND_HDR;
      end else begin
        case (kind_q)
          KIND_HDR: kind_d = KIND_PC;
          KIND_PC:  kind_d = has_rd ? KIND_RD : KIND_MEM;
          KIND_RD:  kind_d = KIND_MEM;
          default:  kind_d = KIND_HDR;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      kind_q <= KIND_HDR;
    end else begin
      busy_q <= busy_d;
      kind_q <= kind_d;
    end
  end

  //////////////////////////////
  // Word build
  //////////////////////////////

  always_comb begin
    fifo_word = '0;
    case (kind_q)
      KIND_HDR: begin
        // Header view
        fifo_word.hdr.kind      = KIND_HDR;
        fifo_word.hdr.has_rd    = has_rd;
        fifo_word.hdr.has_mem   = has_mem;
        fifo_word.hdr.mem_write = ret_entry.mem_write;
        fifo_word.hdr.rd_addr   = ret_entry.rd_addr;
        fifo_word.hdr.delta     = ret_entry.delta;
      end
      // Raw payload views
      KIND_PC:  fifo_word.raw = ret_entry.pc;
      KIND_RD:  fifo_word.raw = ret_entry.rd_wdata;
      default:  fifo_word.raw = ret_entry.mem_addr;
    endcase
  end

endmodule

// File: hdl/trace_word_fifo.sv
`include "rvfi_trace_macros.svh"

module trace_word_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        fifo_push,
  input  rvfi_trace_pkg::trace_word_u fifo_word,
  input  logic                        trace_rd,
  output rvfi_trace_pkg::trace_word_u trace_data,
  output logic                        trace_empty,
  output logic                        fifo_full
);

  import rvfi_trace_pkg::*;

  localparam int DEPTH = `RVFI_TRACE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  trace_word_u      mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Level flags
  assign trace_empty = (count_q == '0);
  assign fifo_full   = (count_q == CNT_W'(DEPTH));

  // Pop on empty is dropped, push on full likewise
  assign push = fifo_push & ~fifo_full;
  assign pop  = trace_rd & ~trace_empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= fifo_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Show-ahead head word
  assign trace_data = mem_q[rd_ptr_q];

endmodule

// File: include/rvfi_trace_macros.svh
`ifndef RVFI_TRACE_MACROS_SVH
`define RVFI_TRACE_MACROS_SVH

//////////////////////////////
// Trace unit sizes
//////////////////////////////

// Retirements held between the core and the record emitter
`define RVFI_TRACE_RETQ_DEPTH 4

// Trace words waiting for the host
`define RVFI_TRACE_FIFO_DEPTH 16

// Cycle delta carried in each header
// Header fields around it take the other 10 bits
`define RVFI_TRACE_DELTA_W 22

`endif
